/* dv/cpuGolden.txt */
# P index word (program), S addr data (expected store, in order)
# R cycles after run rises, H cycle and length of a pause with run low
P 0 00700093 addi x1, x0, 7
P 1 ffd00113 addi x2, x0, -3
P 2 002081b3 add  x3, x1, x2
P 3 00302023 sw   x3, 0(x0)
P 4 40208233 sub  x4, x1, x2
P 5 00402223 sw   x4, 4(x0)
P 6 0020f2b3 and  x5, x1, x2
P 7 00502423 sw   x5, 8(x0)
P 8 0020e333 or   x6, x1, x2
P 9 00602623 sw   x6, 12(x0)
P 10 001123b3 slt  x7, x2, x1
P 11 00702823 sw   x7, 16(x0)
P 12 0020a433 slt  x8, x1, x2
P 13 00802a23 sw   x8, 20(x0)
P 14 02402023 sw   x4, 32(x0)
P 15 02002483 lw   x9, 32(x0)
P 16 02902223 sw   x9, 36(x0)
P 17 00500013 addi x0, x0, 5
P 18 02002423 sw   x0, 40(x0)
P 19 00108463 beq  x1, x1, +8
P 20 02102623 sw   x1, 44(x0)
P 21 02202823 sw   x2, 48(x0)
P 22 00208463 beq  x1, x2, +8
P 23 02302a23 sw   x3, 52(x0)
P 24 00000513 addi x10, x0, 0
P 25 00400593 addi x11, x0, 4
P 26 00150513 addi x10, x10, 1
P 27 02a02c23 sw   x10, 56(x0)
P 28 00b50463 beq  x10, x11, +8
P 29 fe000ae3 beq  x0, x0, -12
P 30 00000063 beq  x0, x0, 0
S 00000000 00000004
S 00000004 0000000a
S 00000008 00000005
S 0000000c ffffffff
S 00000010 00000001
S 00000014 00000000
S 00000020 0000000a
S 00000024 0000000a
S 00000028 00000000
S 00000030 fffffffd
S 00000034 00000004
S 00000038 00000001
S 00000038 00000002
S 00000038 00000003
S 00000038 00000004
R 48
H 11 4

/* sim.f */
design/cpuPkg.sv
design/pcUnit.sv
design/instMem.sv
design/regFile.sv
design/decodeControl.sv
design/alu.sv
design/dataMem.sv
design/singleCpu.sv
dv/tbSingleCpu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the single-cycle core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --top-module tbSingleCpu \
    -f sim.f \
    -o simSingleCpu

./obj_dir/simSingleCpu

/* dv/tbSingleCpu.sv */
`timescale 1ns/1ns

module tbSingleCpu;

    import cpuPkg::*;

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 10;

    logic            CLK;
    logic            arstN;
    logic            run;
    loadT            prog;
    logic [xlen-1:0] OUT;
    logic [xlen-1:0] pc;
    storeT           store;

    // Contents of the golden file
    logic [xlen-1:0] progImage [int];   // Word index to program word
    logic [xlen-1:0] expAddr [$];
    logic [xlen-1:0] expData [$];
    int              budget;             // Cycles after run first rises
    int              holdAt;
    int              holdLen;
    int              loadStart;
    longint          limitNs;
    bit              limitSet;

    singleCpu #(
        .imemDepth (64),
        .dmemDepth (64)
    ) u_singleCpu (
        .CLK   (CLK),
        .arstN (arstN),
        .run   (run),
        .prog  (prog),
        .OUT   (OUT),
        .pc    (pc),
        .store (store)
    );

    always #(clkPeriod / 2) CLK = ~CLK;

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkEq(input string what, input logic [xlen-1:0] actual,
                           input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            failRun("Value mismatch");
        end
    endtask

    task automatic readGolden();
        int              fd;
        int              fields;
        int              need;
        int              idx;
        byte             tag;
        string           line;
        string           rest;
        logic [xlen-1:0] addr;
        logic [xlen-1:0] word;
        budget  = 0;
        holdAt  = -1;   // No pause unless an H record exists
        holdLen = 0;
        fd = $fopen("dv/cpuGolden.txt", "r");
        if (fd == 0) begin
            failRun("Cannot open the golden file dv/cpuGolden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2) continue;
                tag = line.getc(0);
                if (tag == "#") continue;
                rest = line.substr(1, line.len() - 1);
                case (tag)
                    "P": begin
                        need   = 2;
                        fields = $sscanf(rest, "%d %h", idx, word);
                        progImage[idx] = word;
                    end
                    "S": begin
                        need   = 2;
                        fields = $sscanf(rest, "%h %h", addr, word);
                        expAddr.push_back(addr);
                        expData.push_back(word);
                    end
                    "R": begin
                        need   = 1;
                        fields = $sscanf(rest, "%d", budget);
                    end
                    "H": begin
                        need   = 2;
                        fields = $sscanf(rest, "%d %d", holdAt, holdLen);
                    end
                    default: begin
                        need   = 0;
                        fields = -1;
                    end
                endcase
                if (fields != need) begin
                    failRun($sformatf("Malformed golden record: %s", line));
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic releaseReset();
        repeat (resetCycles) @(posedge CLK);
        #1;
        arstN = 1'b1;
        @(negedge CLK);
        checkEq("pc after reset", pc, '0);
        checkEq("store.valid after reset", xlen'(store.valid), '0);
    endtask

    // Load runs while run is low and may overlap reset
    task automatic loadProgram();
        repeat (loadStart) @(posedge CLK);
        foreach (progImage[i]) begin
            #1;
            prog = '{we: 1'b1, addr: xlen'(i), data: progImage[i]};
            @(posedge CLK);
        end
        #1;
        prog = '0;
    endtask

    task automatic checkStore();
        if (expAddr.size() == 0) begin
            failRun($sformatf("Unexpected store at %0t ns to address %h", $time, store.addr));
        end else begin
            checkEq("store address", store.addr, expAddr.pop_front());
            checkEq("store data", store.data, expData.pop_front());
        end
    endtask

    task automatic runProgram();
        logic [xlen-1:0] heldPc;
        bit              paused;
        heldPc = '0;
        for (int cyc = 0; cyc < budget; cyc++) begin
            paused = (cyc >= holdAt) && (cyc < holdAt + holdLen);
            @(posedge CLK);
            #1;
            run = !paused;
            @(negedge CLK);   // Outputs settled mid cycle
            if (paused) begin
                if (cyc == holdAt) begin
                    heldPc = pc;  // Last edge with run high just passed
                end else begin
                    checkEq("pc while run is low", pc, heldPc);
                end
                checkEq("store.valid while run is low", xlen'(store.valid), '0);
            end else if (store.valid) begin
                checkStore();
            end
        end
        @(posedge CLK);
        #1;
        run = 1'b0;
    endtask

    initial begin
        CLK   = 1'b0;
        arstN = 1'b0;
        run   = 1'b0;
        prog  = '0;
        void'($urandom(33));
        loadStart = 1 + ($urandom % (resetCycles - 1));
        readGolden();
        limitNs  = longint'(progImage.num() + budget + 20) * clkPeriod;
        limitSet = 1'b1;
        fork
            releaseReset();
            loadProgram();
        join
        @(negedge CLK);
        checkEq("OUT after load", OUT, progImage[0]);
        runProgram();
        if (expAddr.size() != 0) begin
            failRun($sformatf("%0d expected stores did not happen", expAddr.size()));
        end else begin
            $display("No errors");
            $finish;
        end
    end

    // Watchdog
    initial begin
        wait (limitSet);
        #(limitNs);
        failRun("Timeout: the program did not finish within the cycle limit");
    end

endmodule

/* design/singleCpu.sv */
`timescale 1ns/1ns

module singleCpu #(
    parameter int imemDepth = 64,
    parameter int dmemDepth = 64
) (
    input  logic                     CLK,
    input  logic                     arstN,
    input  logic                     run,
    input  cpuPkg::loadT             prog,
    output logic [cpuPkg::xlen-1:0]  OUT,
    output logic [cpuPkg::xlen-1:0]  pc,
    output cpuPkg::storeT            store
);

    import cpuPkg::*;

    logic [xlen-1:0] inst;
    ctrlT            ctrl;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] result;
    logic            zero;
    logic [xlen-1:0] memData;
    logic [xlen-1:0] wbData;
    logic            taken;

    assign OUT   = inst;                // Instruction now executing
    assign taken = ctrl.branch & zero;

    pcUnit u_pcUnit (
        .CLK   (CLK),
        .arstN (arstN),
        .run   (run),
        .taken (taken),
        .imm   (ctrl.imm),
        .pc    (pc)
    );

    instMem #(.imemDepth(imemDepth)) u_instMem (
        .CLK  (CLK),
        .prog (prog),
        .pc   (pc),
        .inst (inst)
    );

    decodeControl u_decodeControl (
        .inst (inst),
        .ctrl (ctrl)
    );

    // Register indices come straight from the fixed fields
    regFile u_regFile (
        .CLK   (CLK),
        .arstN (arstN),
        .rs1   (inst[rs1Lsb +: 5]),
        .rs2   (inst[rs2Lsb +: 5]),
        .rd    (inst[rdLsb +: 5]),
        .we    (ctrl.regWrite & run),
        .wd    (wbData),
        .rd1   (rd1),
        .rd2   (rd2)
    );

    assign aluB = ctrl.aluSrc ? ctrl.imm : rd2;

    alu u_alu (
        .a      (rd1),
        .b      (aluB),
        .op     (ctrl.aluOp),
        .result (result),
        .zero   (zero)
    );

    // Same struct feeds memory and the port
    assign store = '{valid: ctrl.memWrite & run, addr: result, data: rd2};

    dataMem #(.dmemDepth(dmemDepth)) u_dataMem (
        .CLK   (CLK),
        .store (store),
        .addr  (result),
        .rdata (memData)
    );

    assign wbData = (ctrl.memToReg && ctrl.memRead) ? memData : result;

endmodule

/* design/dataMem.sv */
`timescale 1ns/1ns

module dataMem #(
    parameter int dmemDepth = 64
) (
    input  logic                     CLK,
    input  cpuPkg::storeT            store,
    input  logic [cpuPkg::xlen-1:0]  addr,
    output logic [cpuPkg::xlen-1:0]  rdata
);

    import cpuPkg::*;

    localparam int addrW = $clog2(dmemDepth);

    logic [xlen-1:0]  mem [dmemDepth];
    logic [addrW-1:0] wrIdx;
    logic [addrW-1:0] rdIdx;

    // Byte addresses to word index, wrapping at depth
    assign wrIdx = store.addr[addrW+1:2];
    assign rdIdx = addr[addrW+1:2];

    always_ff @(posedge CLK) begin
        if (store.valid) begin
            mem[wrIdx] <= store.data;
        end
    end

    assign rdata = mem[rdIdx];

endmodule

/* design/alu.sv */
`timescale 1ns/1ns

module alu (
    input  logic [cpuPkg::xlen-1:0]  a,
    input  logic [cpuPkg::xlen-1:0]  b,
    input  cpuPkg::aluOpE            op,
    output logic [cpuPkg::xlen-1:0]  result,
    output logic                     zero
);

    import cpuPkg::*;

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {{(xlen-1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

    assign zero = (result == '0);  // beq taken when operands match

endmodule

/* design/decodeControl.sv */
`timescale 1ns/1ns

module decodeControl (
    input  logic [cpuPkg::xlen-1:0]  inst,
    output cpuPkg::ctrlT             ctrl
);

    import cpuPkg::*;

    opcodeE          opcode;
    logic [2:0]      funct3;
    logic            funct7b5;   // Bit 30, selects sub
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;

    assign opcode   = opcodeE'(inst[opLsb +: 7]);
    assign funct3   = inst[funct3Lsb +: 3];
    assign funct7b5 = inst[30];

    // Immediate forms
    assign immI = {{20{inst[31]}}, inst[31:20]};
    assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

    always_comb begin
        ctrl       = '0;      // Unknown opcodes retire as no-ops
        ctrl.aluOp = aluAdd;
        case (opcode)
            opR: begin
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = funct7b5 ? aluSub : aluAdd;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    default: ctrl.regWrite = 1'b0;  // Shifts, xor, sltu
                endcase
            end
            opImm: begin
                ctrl.aluSrc = 1'b1;
                ctrl.imm    = immI;
                ctrl.regWrite = 1'b1;
                case (funct3)
                    3'b000:  ctrl.aluOp = aluAdd;
                    3'b010:  ctrl.aluOp = aluSlt;
                    3'b110:  ctrl.aluOp = aluOr;
                    3'b111:  ctrl.aluOp = aluAnd;
                    default: ctrl.regWrite = 1'b0;
                endcase
            end
            opLoad: begin
                if (funct3 == 3'b010) begin  // lw only
                    ctrl.regWrite = 1'b1;
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memRead  = 1'b1;
                    ctrl.memToReg = 1'b1;
                    ctrl.imm      = immI;
                end
            end
            opStore: begin
                if (funct3 == 3'b010) begin  // sw only
                    ctrl.aluSrc   = 1'b1;
                    ctrl.memWrite = 1'b1;
                    ctrl.imm      = immS;
                end
            end
            opBranch: begin
                // beq compares by subtracting and checking zero
                if (funct3 == 3'b000) begin
                    ctrl.branch = 1'b1;
                    ctrl.aluOp  = aluSub;
                    ctrl.imm    = immB;
                end
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ns

module regFile (
    input  logic                     CLK,
    input  logic                     arstN,
    input  logic [4:0]               rs1,
    input  logic [4:0]               rs2,
    input  logic [4:0]               rd,
    input  logic                     we,
    input  logic [cpuPkg::xlen-1:0]  wd,
    output logic [cpuPkg::xlen-1:0]  rd1,
    output logic [cpuPkg::xlen-1:0]  rd2
);

    import cpuPkg::*;

    logic [xlen-1:0] regs [32];

    // x0 is never written so it stays at its reset value
    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin
            regs[rd] <= wd;
        end
    end

    // Same cycle read returns the old value
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

/* design/instMem.sv */
`timescale 1ns/1ns

module instMem #(
    parameter int imemDepth = 64
) (
    input  logic                     CLK,
    input  cpuPkg::loadT             prog,
    input  logic [cpuPkg::xlen-1:0]  pc,
    output logic [cpuPkg::xlen-1:0]  inst
);

    import cpuPkg::*;

    localparam int addrW = $clog2(imemDepth);

    logic [xlen-1:0]  mem [imemDepth];
    logic [addrW-1:0] loadIdx;
    logic [addrW-1:0] fetchIdx;

    assign loadIdx  = prog.addr[addrW-1:0];  // Word index, wraps at depth
    assign fetchIdx = pc[addrW+1:2];         // Byte address to word

    // Program load
    always_ff @(posedge CLK) begin
        if (prog.we) begin
            mem[loadIdx] <= prog.data;
        end
    end

    assign inst = mem[fetchIdx];

endmodule

/* design/pcUnit.sv */
`timescale 1ns/1ns

module pcUnit (
    input  logic                     CLK,
    input  logic                     arstN,
    input  logic                     run,
    input  logic                     taken,
    input  logic [cpuPkg::xlen-1:0]  imm,
    output logic [cpuPkg::xlen-1:0]  pc
);

    import cpuPkg::*;

    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcTarget;
    logic [xlen-1:0] pcNext;

    assign pcPlus4  = pc + xlen'(4);
    assign pcTarget = pc + imm;  // beq offset is relative to this instruction

    // Branch target wins over the sequential address
    assign pcNext = taken ? pcTarget : pcPlus4;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= pcNext;
        end
    end

endmodule

/* design/cpuPkg.sv */
package cpuPkg;

    // Data word and byte address width
    localparam int xlen = 32;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,  // add, sub, and, or, slt
        opImm    = 7'b0010011,  // addi
        opLoad   = 7'b0000011,  // lw
        opStore  = 7'b0100011,  // sw
        opBranch = 7'b1100011   // beq
    } opcodeE;

    // ALU operations, aluAdd is the idle value
    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4
    } aluOpE;

    // Decoded controls for one instruction
    typedef struct packed {
        logic             regWrite;
        logic             aluSrc;    // Second operand is imm
        logic             memRead;
        logic             memWrite;
        logic             memToReg;
        logic             branch;
        aluOpE            aluOp;
        logic [xlen-1:0]  imm;       // Sign extended, B form already in bytes
    } ctrlT;

    // One data memory write, also seen on the store port
    typedef struct packed {
        logic             valid;
        logic [xlen-1:0]  addr;      // Byte address
        logic [xlen-1:0]  data;
    } storeT;

    // Program load port into instruction memory
    typedef struct packed {
        logic             we;
        logic [xlen-1:0]  addr;      // Word index
        logic [xlen-1:0]  data;
    } loadT;

    // Instruction field positions
    localparam int opLsb     = 0;
    localparam int rdLsb     = 7;
    localparam int funct3Lsb = 12;
    localparam int rs1Lsb    = 15;
    localparam int rs2Lsb    = 20;

endpackage
